/* Bender.yml */
package:
  name: logCorr

sources:
  # rtl, package first
  - files:
      - design/logCorrPkg.sv
      - design/descEncoder.sv
      - design/descStore.sv
      - design/windowCorrelator.sv
      - design/logCorrTop.sv

  # testbench
  - target: simulation
    files:
      - dv/logCorr_checker.sv
      - dv/logCorrMonitor.sv
      - dv/logCorrTb.sv

/* design/descEncoder.sv */
`timescale 1ns/100ps
`default_nettype none

module descEncoder #(
	parameter int numPixels = 16,
	localparam int wordAw = (numPixels > 4) ? $clog2(numPixels / 4) : 1
) (
	input  logic clk,
	input  logic rst,
	input  logic [31:0] descData,
	input  logic descValid,
	output logic wrEn,
	output logic [wordAw-1:0] wrAddr,
	output logic [4*logCorrPkg::logWidth-1:0] wrData,
	output logic descLoaded
);
	import logCorrPkg::*;

	localparam int numWords = numPixels / 4;
	localparam logic stWait = 1'b0;
	localparam logic stLoad = 1'b1;

	logic state;
	logic nextState;
	logic [31:0] wordReg;
	logic [wordAw-1:0] wordCnt;
	logic lastWord;
	logWord_t pixLog [4];

	assign wrEn = (state == stLoad);
	assign wrAddr = wordCnt;
	assign lastWord = (wordCnt == wordAw'(numWords - 1));

	// a strobe during load keeps the FSM in load for the next word
	always_comb begin
		nextState = state;
		case (state)
			stWait: begin
				if (descValid) begin
					nextState = stLoad;
				end
			end
			stLoad: begin
				if (!descValid) begin
					nextState = stWait;
				end
			end
			default: begin
				nextState = stWait;
			end
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= stWait;
			wordCnt <= '0;
			descLoaded <= 1'b0;
		end else begin
			state <= nextState;
			if (wrEn) begin
				wordCnt <= lastWord ? '0 : wordCnt + 1'b1;
				if (lastWord) begin
					descLoaded <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (descValid) begin
			wordReg <= descData;
		end
	end

	// byte 31..24 is the first pixel of the word
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			pixLog[k] = byteToLog(wordReg[(3 - k) * 8 +: 8], 1'b0);
			wrData[(3 - k) * logWidth +: logWidth] = pixLog[k].raw;
		end
	end

endmodule

`default_nettype wire

/* design/descStore.sv */
`timescale 1ns/100ps
`default_nettype none

module descStore #(
	parameter int numPixels = 16,
	localparam int wordAw = (numPixels > 4) ? $clog2(numPixels / 4) : 1,
	localparam int pixAw = $clog2(numPixels)
) (
	input  logic clk,
	input  logic rst,
	input  logic wrEn,
	input  logic [wordAw-1:0] wrAddr,
	input  logic [4*logCorrPkg::logWidth-1:0] wrData,
	input  logic [pixAw-1:0] rdAddr,
	output logic [logCorrPkg::logWidth-1:0] rdData
);
	import logCorrPkg::*;

	logic [logWidth-1:0] mem [numPixels];

	// one word fills four neighbouring pixels
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < numPixels; i++) begin
				mem[i] <= '0;
			end
		end else if (wrEn) begin
			for (int k = 0; k < 4; k++) begin
				mem[int'(wrAddr) * 4 + k] <= wrData[(3 - k) * logWidth +: logWidth];
			end
		end
	end

	assign rdData = mem[rdAddr];

endmodule

`default_nettype wire

/* design/logCorrPkg.sv */
`default_nettype none

package logCorrPkg;

	localparam int logWidth = 14;
	localparam int charWidth = 5;
	localparam int mantWidth = 7;
	localparam int scoreWidth = 24;

	// log word, seen as fields or as a plain vector
	typedef union packed {
		struct packed {
			logic sign;
			logic zero;
			logic [charWidth-1:0] charac;
			logic [mantWidth-1:0] mant;
		} f;
		logic [logWidth-1:0] raw;
	} logWord_t;

	// leading-one position becomes the characteristic,
	// the bits below it become the mantissa
	function automatic logWord_t byteToLog(input logic [7:0] mag, input logic sign);
		logWord_t word;
		logic [2:0] lead;
		logic [7:0] aligned;
		lead = '0;
		for (int i = 1; i < 8; i++) begin
			if (mag[i]) begin
				lead = 3'(i);
			end
		end
		// drop the leading one off the top
		aligned = mag << (3'd7 - lead);
		word.raw = '0;
		if (mag == 8'd0) begin
			word.f.zero = 1'b1;
		end else begin
			word.f.sign = sign;
			word.f.charac = charWidth'(lead);
			word.f.mant = aligned[mantWidth-1:0];
		end
		return word;
	endfunction

	// antilog of a summed log pair, fraction bits truncated
	function automatic logic [scoreWidth-1:0] logToInt(
		input logic [charWidth:0] charSum,
		input logic [mantWidth:0] mantSum
	);
		logic [charWidth+1:0] shiftAmt;
		logic [31:0] scaled;
		// mantissa carry moves into the characteristic
		shiftAmt = {1'b0, charSum} + (charWidth + 2)'(mantSum[mantWidth]);
		scaled = {24'd0, 1'b1, mantSum[mantWidth-1:0]} << shiftAmt;
		return scaled[mantWidth +: scoreWidth];
	endfunction

endpackage

`default_nettype wire

/* design/logCorrTop.sv */
`timescale 1ns/100ps
`default_nettype none

module logCorrTop #(
	parameter int numPixels = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic [31:0] descData,
	input  logic descValid,
	input  logic signed [7:0] winPixel,
	input  logic winValid,
	output logic descLoaded,
	output logic signed [logCorrPkg::scoreWidth-1:0] score,
	output logic scoreValid
);
	import logCorrPkg::*;

	localparam int wordAw = (numPixels > 4) ? $clog2(numPixels / 4) : 1;
	localparam int pixAw = $clog2(numPixels);

	logic wrEn;
	logic [wordAw-1:0] wrAddr;
	logic [4*logWidth-1:0] wrData;
	logic [pixAw-1:0] rdAddr;
	logic [logWidth-1:0] rdData;

	// producer
	descEncoder #(.numPixels(numPixels)) encoder0 (
		.clk(clk),
		.rst(rst),
		.descData(descData),
		.descValid(descValid),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.descLoaded(descLoaded)
	);

	descStore #(.numPixels(numPixels)) store0 (
		.clk(clk),
		.rst(rst),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	// consumer
	windowCorrelator #(.numPixels(numPixels)) corr0 (
		.clk(clk),
		.rst(rst),
		.winPixel(winPixel),
		.winValid(winValid),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.score(score),
		.scoreValid(scoreValid)
	);

endmodule

`default_nettype wire

/* design/windowCorrelator.sv */
`timescale 1ns/100ps
`default_nettype none

module windowCorrelator #(
	parameter int numPixels = 16,
	localparam int pixAw = $clog2(numPixels)
) (
	input  logic clk,
	input  logic rst,
	input  logic signed [7:0] winPixel,
	input  logic winValid,
	output logic [pixAw-1:0] rdAddr,
	input  logic [logCorrPkg::logWidth-1:0] rdData,
	output logic signed [logCorrPkg::scoreWidth-1:0] score,
	output logic scoreValid
);
	import logCorrPkg::*;

	logic [pixAw-1:0] pixIdx;
	logic lastPix;
	logic [7:0] winMag;

	// stage 1
	logWord_t winLog;
	logWord_t descLog;
	logic validS1;
	logic lastS1;

	// stage 2
	logic [charWidth:0] charSum;
	logic [mantWidth:0] mantSum;
	logic [scoreWidth-1:0] prodMag;
	logic signed [scoreWidth-1:0] product;
	logic signed [scoreWidth-1:0] accBase;
	logic signed [scoreWidth-1:0] acc;
	logic lastS2;

	assign rdAddr = pixIdx;
	assign lastPix = (pixIdx == pixAw'(numPixels - 1));

	// -128 folds to magnitude 128
	assign winMag = winPixel[7] ? 8'(-winPixel) : 8'(winPixel);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pixIdx <= '0;
		end else if (winValid) begin
			if (lastPix) begin
				pixIdx <= '0;
			end else begin
				pixIdx <= pixIdx + 1'b1;
			end
		end
	end

	// pixel and descriptor log words for the product
	always_ff @(posedge clk) begin
		if (winValid) begin
			winLog <= byteToLog(winMag, winPixel[7]);
			descLog.raw <= rdData;
		end
	end

	// log add is the multiply
	always_comb begin
		charSum = {1'b0, winLog.f.charac} + {1'b0, descLog.f.charac};
		mantSum = {1'b0, winLog.f.mant} + {1'b0, descLog.f.mant};
		prodMag = logToInt(charSum, mantSum);
		if (winLog.f.zero || descLog.f.zero) begin
			product = '0;
		end else if (winLog.f.sign ^ descLog.f.sign) begin
			product = -$signed(prodMag);
		end else begin
			product = $signed(prodMag);
		end
	end

	// restart once the previous window's sum has been taken
	assign accBase = lastS2 ? '0 : acc;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			validS1 <= 1'b0;
			lastS1 <= 1'b0;
			lastS2 <= 1'b0;
			acc <= '0;
			scoreValid <= 1'b0;
		end else begin
			validS1 <= winValid;
			lastS1 <= winValid & lastPix;
			lastS2 <= lastS1;
			scoreValid <= lastS2;
			if (validS1) begin
				acc <= accBase + product;
			end else begin
				acc <= accBase;
			end
		end
	end

	// final sum of the window
	always_ff @(posedge clk) begin
		if (lastS2) begin
			score <= acc;
		end
	end

endmodule

`default_nettype wire

/* dv/logCorrMonitor.sv */
`timescale 1ns/100ps
`default_nettype none

module logCorrMonitor #(
	parameter int numPixels = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic [31:0] descData,
	input  logic descValid,
	input  logic signed [7:0] winPixel,
	input  logic winValid,
	input  logic descLoaded,
	input  logic signed [logCorrPkg::scoreWidth-1:0] score,
	input  logic scoreValid,
	output int errorCount,
	output int windowsDone
);
	int descPix [numPixels];
	int expScore [$];
	int expEdge [$];
	int cycle;
	int wordIdx;
	int pixIdx;
	int accum;
	int loadEdge;
	logic expLoaded;

	function automatic int msbPos(input int v);
		int p;
		p = 0;
		while ((v >> (p + 1)) != 0) begin
			p++;
		end
		return p;
	endfunction

	// leading-one product of two magnitudes, fraction dropped
	function automatic int approxMul(input int a, input int b);
		int pa;
		int pb;
		int s;
		if (a == 0 || b == 0) begin
			return 0;
		end
		pa = msbPos(a);
		pb = msbPos(b);
		s = (((a - (1 << pa)) << 7) >> pa) + (((b - (1 << pb)) << 7) >> pb);
		if (s < 128) begin
			return ((128 + s) << (pa + pb)) >> 7;
		end
		return (s << (pa + pb + 1)) >> 7;
	endfunction

	always @(posedge clk) begin
		int px;
		int prod;
		int got;
		if (rst) begin
			cycle = 0;
			wordIdx = 0;
			pixIdx = 0;
			accum = 0;
			loadEdge = -1;
			errorCount = 0;
			windowsDone = 0;
			expScore.delete();
			expEdge.delete();
		end else begin
			cycle++;
			// outputs sampled here were set at the previous edge
			expLoaded = (loadEdge >= 0) && (cycle - 1 >= loadEdge);
			if (descLoaded !== expLoaded) begin
				$display("mismatch at %0t: descLoaded is %b, expected %b", $time, descLoaded,
					expLoaded);
				errorCount++;
			end
			if (scoreValid === 1'b1) begin
				if (expScore.size() == 0) begin
					$display("error at %0t: scoreValid pulsed with no window finished", $time);
					errorCount++;
				end else begin
					got = score;
					if (cycle - 1 != expEdge[0]) begin
						$display("mismatch at %0t: score issued at edge %0d, expected edge %0d",
							$time, cycle - 1, expEdge[0]);
						errorCount++;
					end
					if (got != expScore[0]) begin
						$display("mismatch at %0t: score is %0d, expected %0d", $time, got,
							expScore[0]);
						errorCount++;
					end
					void'(expScore.pop_front());
					void'(expEdge.pop_front());
					windowsDone++;
				end
			end else if (expEdge.size() > 0 && cycle - 1 > expEdge[0]) begin
				$display("error at %0t: no score was issued for a finished window", $time);
				errorCount++;
				void'(expScore.pop_front());
				void'(expEdge.pop_front());
				windowsDone++;
			end
			if (descValid) begin
				for (int k = 0; k < 4; k++) begin
					descPix[wordIdx * 4 + k] = descData[31 - 8 * k -: 8];
				end
				if (wordIdx == numPixels / 4 - 1) begin
					wordIdx = 0;
					if (loadEdge < 0) begin
						loadEdge = cycle + 1;
					end
				end else begin
					wordIdx++;
				end
			end
			if (winValid) begin
				px = winPixel;
				prod = approxMul((px < 0) ? -px : px, descPix[pixIdx]);
				accum += (px < 0) ? -prod : prod;
				if (pixIdx == numPixels - 1) begin
					expScore.push_back(accum);
					expEdge.push_back(cycle + 2);
					accum = 0;
					pixIdx = 0;
				end else begin
					pixIdx++;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* dv/logCorrTb.sv */
`timescale 1ns/100ps
`default_nettype none

module logCorrTb;
	import logCorrPkg::*;

	localparam int numPixels = 16;
	localparam int numWords = numPixels / 4;
	localparam int descWords = 3 * numWords;
	localparam int numWindows = 14;
	// a descriptor word can take up to four cycles with its gap
	localparam int timeoutCycles = descWords * 4 + numWindows * numPixels * 2 + 200;
	localparam logic [7:0] edgeDesc [8] = '{8'h00, 8'hff, 8'h01, 8'h80, 8'hff, 8'h01, 8'h40,
		8'h03};
	localparam logic [7:0] edgeWin [8] = '{8'h80, 8'h7f, 8'h01, 8'h00, 8'hff, 8'h80, 8'h01,
		8'h7f};

	logic clk;
	logic rst;
	logic [31:0] descData;
	logic descValid;
	logic signed [7:0] winPixel;
	logic winValid;
	logic descLoaded;
	logic signed [scoreWidth-1:0] score;
	logic scoreValid;
	int errorCount;
	int windowsDone;
	int windowsSent;
	logic [31:0] rngState;
	logic [7:0] descPix [numPixels];
	logic [7:0] winSet [4][numPixels];

	always #5 clk = ~clk;

	logCorrTop #(.numPixels(numPixels)) dut0 (
		.clk(clk),
		.rst(rst),
		.descData(descData),
		.descValid(descValid),
		.winPixel(winPixel),
		.winValid(winValid),
		.descLoaded(descLoaded),
		.score(score),
		.scoreValid(scoreValid)
	);

	logCorrMonitor #(.numPixels(numPixels)) mon0 (
		.clk(clk),
		.rst(rst),
		.descData(descData),
		.descValid(descValid),
		.winPixel(winPixel),
		.winValid(winValid),
		.descLoaded(descLoaded),
		.score(score),
		.scoreValid(scoreValid),
		.errorCount(errorCount),
		.windowsDone(windowsDone)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic drawByte(output logic [7:0] b);
		rngState = lcgNext(rngState);
		b = rngState[31:24];
	endtask

	task automatic randomDescriptor();
		for (int i = 0; i < numPixels; i++) begin
			drawByte(descPix[i]);
		end
	endtask

	task automatic randomWindows(input int n);
		for (int w = 0; w < n; w++) begin
			for (int i = 0; i < numPixels; i++) begin
				drawByte(winSet[w][i]);
			end
		end
	endtask

	task automatic loadDescriptor(input bit gapped);
		logic [7:0] gap;
		for (int w = 0; w < numWords; w++) begin
			drawByte(gap);
			descValid = 1'b0;
			repeat (gapped ? gap % 4 : 0) @(negedge clk);
			descData = {descPix[4 * w], descPix[4 * w + 1], descPix[4 * w + 2],
				descPix[4 * w + 3]};
			descValid = 1'b1;
			@(negedge clk);
		end
		descValid = 1'b0;
		while (!descLoaded) begin
			@(negedge clk);
		end
		// last word reaches the store one edge after its strobe
		repeat (2) @(negedge clk);
	endtask

	task automatic sendWindow(input int idx, input bit gapped);
		logic [7:0] gap;
		for (int i = 0; i < numPixels; i++) begin
			drawByte(gap);
			winValid = 1'b0;
			repeat ((gapped && gap[7]) ? 1 : 0) @(negedge clk);
			winPixel = winSet[idx][i];
			winValid = 1'b1;
			@(negedge clk);
		end
		winValid = 1'b0;
		windowsSent++;
	endtask

	task automatic waitScores();
		while (windowsDone < windowsSent) begin
			@(negedge clk);
		end
	endtask

	initial begin
		int failTotal;
		clk = 1'b0;
		rst = 1'b1;
		descData = '0;
		descValid = 1'b0;
		winPixel = '0;
		winValid = 1'b0;
		rngState = 32'hf6fcda2f;
		windowsSent = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);
		// same windows back to back, then with gaps
		randomDescriptor();
		loadDescriptor(1'b1);
		randomWindows(4);
		for (int w = 0; w < 4; w++) begin
			sendWindow(w, 1'b0);
		end
		waitScores();
		for (int w = 0; w < 4; w++) begin
			sendWindow(w, 1'b1);
		end
		waitScores();
		// zero, full scale, -128 and mantissa carry
		for (int i = 0; i < numPixels; i++) begin
			descPix[i] = edgeDesc[i % 8];
			winSet[0][i] = edgeWin[i % 8];
			winSet[1][i] = edgeWin[(i + 3) % 8];
			winSet[2][i] = 8'h80;
		end
		loadDescriptor(1'b0);
		for (int w = 0; w < 3; w++) begin
			sendWindow(w, w == 1);
		end
		waitScores();
		// reload, scores must follow the new descriptor
		randomDescriptor();
		loadDescriptor(1'b1);
		randomWindows(3);
		for (int w = 0; w < 3; w++) begin
			sendWindow(w, w == 2);
		end
		waitScores();
		repeat (5) @(negedge clk);
		failTotal = errorCount + dut0.check0.failCount;
		$display("%0d errors (%0d monitor, %0d assertion), %0d windows checked", failTotal,
			errorCount, dut0.check0.failCount, windowsDone);
		if (failTotal == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/logCorr_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module logCorr_checker (
	input  logic clk,
	input  logic rst,
	input  logic wrEn,
	input  logic descLoaded,
	input  logic scoreValid
);
	int failCount = 0;

	// descriptor is never loaded coming out of reset
	resetLow: assert property (@(posedge clk) $fell(rst) |-> !descLoaded)
		else begin
			failCount++;
			$error("descLoaded high right after reset");
		end

	// only a store write can raise it
	loadAfterWrite: assert property (@(posedge clk) disable iff (rst)
		$rose(descLoaded) |-> $past(wrEn))
		else begin
			failCount++;
			$error("descLoaded rose without a store write");
		end

	scorePulse: assert property (@(posedge clk) disable iff (rst)
		scoreValid |=> !scoreValid)
		else begin
			failCount++;
			$error("scoreValid held for more than one cycle");
		end

	scoreNeedsDesc: assert property (@(posedge clk) disable iff (rst)
		$rose(scoreValid) |-> descLoaded)
		else begin
			failCount++;
			$error("scoreValid rose before a descriptor was loaded");
		end

endmodule

bind logCorrTop logCorr_checker check0 (
	.clk(clk),
	.rst(rst),
	.wrEn(wrEn),
	.descLoaded(descLoaded),
	.scoreValid(scoreValid)
);

`default_nettype wire

/* logCorr.f */
design/logCorrPkg.sv
design/descEncoder.sv
design/descStore.sv
design/windowCorrelator.sv
design/logCorrTop.sv
dv/logCorr_checker.sv
dv/logCorrMonitor.sv
dv/logCorrTb.sv
